// ==== include/fm_defines.svh ====
// fm register interface constants for the register map, busy length and slot geometry
`ifndef FM_DEFINES_SVH
`define FM_DEFINES_SVH

// global registers below the channel space
`define FM_REG_LFO_RST  8'h01
`define FM_REG_KON      8'h08
`define FM_REG_NOISE    8'h0F
`define FM_REG_CLKA1    8'h10   // upper 8 bits of timer a
`define FM_REG_CLKA2    8'h11   // lower 2 bits of timer a
`define FM_REG_CLKB     8'h12
`define FM_REG_TIMER    8'h14
`define FM_REG_LFRQ     8'h18
`define FM_REG_PMDAMD   8'h19
`define FM_REG_CTW      8'h1B

// start of per-channel and per-operator spaces
`define FM_CH_BASE      8'h20
`define FM_OP_BASE      8'h40

// busy lasts this many cen pulses after a data write
`define FM_BUSY_CEN     32

// slot geometry
`define FM_CHANNELS     8
`define FM_SLOTS        32
`define FM_KON_OPS      4       // operators touched by one key-on write

`endif

// ==== source/fm_pkg.sv ====
// fm register interface types for parameter structs, update requests and fsm states
package fm_pkg;

    typedef struct packed {
        logic [1:0] rl;
        logic [2:0] fb;
        logic [2:0] con;
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
    } ch_params_t;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amsen;
        logic [4:0] d1r;
        logic [1:0] dt2;
        logic [4:0] d2r;
        logic [3:0] d1l;
        logic [3:0] rr;
        logic       keyon;
    } op_params_t;

    typedef enum logic [1:0] {
        UPD_CH,
        UPD_OP,
        UPD_KON
    } upd_kind_t;

    typedef struct packed {
        upd_kind_t  kind;
        logic [2:0] grp;    // field group within the entry
        logic [4:0] idx;    // channel or operator slot
        logic [7:0] data;
    } upd_req_t;

    typedef struct packed {
        logic       ne;
        logic [4:0] nfrq;
        logic [7:0] lfo_freq;
        logic [1:0] lfo_w;
        logic [6:0] lfo_amd;
        logic [6:0] lfo_pmd;
        logic       ct1;
        logic       ct2;
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       enable_irq_a;
        logic       enable_irq_b;
    } fm_globals_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_KEYON
    } upd_state_t;

endpackage

// ==== source/fm_slot_regs.sv ====
// fm parameter store as a flop array with one write port and two read ports
module fm_slot_regs #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] wr_idx,
    input  payload_t                 wr_data,
    input  logic [$clog2(DEPTH)-1:0] upd_idx,
    input  logic [$clog2(DEPTH)-1:0] slot_idx,
    output payload_t                 upd_data,
    output payload_t                 slot_data
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // both reads are combinational
    assign upd_data  = mem[upd_idx];    // read side of the update engine
    assign slot_data = mem[slot_idx];   // follows the slot counter

endmodule

// ==== source/fm_slot_counter.sv ====
// fm slot counter stepping through the 32 operator slots on each cen
`include "fm_defines.svh"

module fm_slot_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    output logic [4:0] cur_slot,
    output logic       zero
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_slot <= '0;
        end else if (cen) begin
            if (cur_slot == 5'(`FM_SLOTS - 1)) begin
                cur_slot <= '0;     // wrap to start of revolution
            end else begin
                cur_slot <= cur_slot + 5'd1;
            end
        end
    end

    assign zero = (cur_slot == 5'd0);   // marks slot 0 of each revolution

endmodule

// ==== source/fm_update_fsm.sv ====
// fm parameter update engine doing read-modify-write of channel and operator entries
`include "fm_defines.svh"

module fm_update_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic               upd_valid,
    input  fm_pkg::upd_req_t   upd_req,
    input  fm_pkg::ch_params_t ch_rd_data,
    input  fm_pkg::op_params_t op_rd_data,
    output logic [2:0]         ch_rd_idx,
    output logic [4:0]         op_rd_idx,
    output logic               ch_we,
    output logic               op_we,
    output fm_pkg::ch_params_t ch_wr_data,
    output fm_pkg::op_params_t op_wr_data
);
    import fm_pkg::*;

    upd_state_t state;
    upd_req_t   req;        // request held while writing
    logic [1:0] op_cnt;     // key-on operator step
    logic [3:0] kon_mask;

    assign kon_mask = req.data[6:3];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            op_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    op_cnt <= '0;
                    if (upd_valid) begin
                        state <= (upd_req.kind == UPD_KON) ? ST_KEYON : ST_WRITE;
                    end
                end
                ST_WRITE: state <= ST_IDLE;
                ST_KEYON: begin
                    op_cnt <= op_cnt + 2'd1;
                    if (op_cnt == 2'(`FM_KON_OPS - 1)) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && upd_valid) begin
            req <= upd_req;
        end
    end

    assign ch_rd_idx = req.idx[2:0];
    assign op_rd_idx = (state == ST_KEYON) ? {op_cnt, req.data[2:0]} : req.idx;
    assign ch_we     = (state == ST_WRITE) && (req.kind == UPD_CH);
    assign op_we     = ((state == ST_WRITE) && (req.kind == UPD_OP)) || (state == ST_KEYON);

    // merge only the addressed group and pass the rest through
    always_comb begin
        ch_wr_data = ch_rd_data;
        case (req.grp[1:0])
            2'd0: begin
                ch_wr_data.rl  = req.data[7:6];
                ch_wr_data.fb  = req.data[5:3];
                ch_wr_data.con = req.data[2:0];
            end
            2'd1: ch_wr_data.kc = req.data[6:0];
            2'd2: ch_wr_data.kf = req.data[7:2];
            default: begin
                ch_wr_data.pms = req.data[6:4];
                ch_wr_data.ams = req.data[1:0];
            end
        endcase
    end

    always_comb begin
        op_wr_data = op_rd_data;
        if (state == ST_KEYON) begin
            op_wr_data.keyon = kon_mask[op_cnt];
        end else begin
            case (req.grp)
                3'd2: {op_wr_data.dt1, op_wr_data.mul} = {req.data[6:4], req.data[3:0]};
                3'd3: op_wr_data.tl = req.data[6:0];
                3'd4: {op_wr_data.ks, op_wr_data.ar} = {req.data[7:6], req.data[4:0]};
                3'd5: {op_wr_data.amsen, op_wr_data.d1r} = {req.data[7], req.data[4:0]};
                3'd6: {op_wr_data.dt2, op_wr_data.d2r} = {req.data[7:6], req.data[4:0]};
                3'd7: {op_wr_data.d1l, op_wr_data.rr} = {req.data[7:4], req.data[3:0]};
                default: ;  // groups 0 and 1 are not mapped
            endcase
        end
    end

endmodule

// ==== source/fm_mmr.sv ====
// fm host register decoder that holds globals, timer flags and busy and issues update requests
`include "fm_defines.svh"

module fm_mmr (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [7:0]          din,
    input  logic                write,
    input  logic                a0,
    input  logic                load_ack_a,
    input  logic                load_ack_b,
    input  logic                clr_ack_a,
    input  logic                clr_ack_b,
    output logic                busy,
    output fm_pkg::fm_globals_t globals,
    output logic                lfo_rst,
    output logic                load_a,
    output logic                load_b,
    output logic                clr_flag_a,
    output logic                clr_flag_b,
    output logic                upd_valid,
    output fm_pkg::upd_req_t    upd_req
);
    import fm_pkg::*;

    logic [7:0] sel_reg;        // address latched by a0 low writes
    logic [4:0] busy_cnt;
    logic       last_write;
    logic       data_wr;

    assign data_wr = write & a0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_reg    <= '0;
            globals    <= '0;
            lfo_rst    <= 1'b0;
            load_a     <= 1'b0;
            load_b     <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            upd_valid  <= 1'b0;
            upd_req    <= '0;
        end else begin
            upd_valid <= 1'b0;  // single clk pulse
            if (write && !a0) begin
                sel_reg <= din;
            end
            if (data_wr) begin
                if (sel_reg < `FM_CH_BASE) begin
                    case (sel_reg)
                        `FM_REG_LFO_RST: lfo_rst <= 1'b1;   // data ignored
                        `FM_REG_KON: begin
                            upd_valid <= 1'b1;
                            upd_req   <= '{kind: UPD_KON, grp: 3'd0, idx: 5'd0, data: din};
                        end
                        `FM_REG_NOISE: begin
                            globals.ne   <= din[7];
                            globals.nfrq <= din[4:0];
                        end
                        `FM_REG_CLKA1: globals.value_a[9:2] <= din;
                        `FM_REG_CLKA2: globals.value_a[1:0] <= din[1:0];
                        `FM_REG_CLKB:  globals.value_b      <= din;
                        `FM_REG_TIMER: begin
                            globals.enable_irq_b <= din[3];
                            globals.enable_irq_a <= din[2];
                            if (din[5]) clr_flag_b <= 1'b1;
                            if (din[4]) clr_flag_a <= 1'b1;
                            if (din[1]) load_b <= 1'b1;
                            if (din[0]) load_a <= 1'b1;
                        end
                        `FM_REG_LFRQ: globals.lfo_freq <= din;
                        `FM_REG_PMDAMD: begin
                            if (din[7]) begin
                                globals.lfo_pmd <= din[6:0];
                            end else begin
                                globals.lfo_amd <= din[6:0];
                            end
                        end
                        `FM_REG_CTW: begin
                            globals.ct2   <= din[7];
                            globals.ct1   <= din[6];
                            globals.lfo_w <= din[1:0];
                        end
                        default: ;
                    endcase
                end else if (sel_reg < `FM_OP_BASE) begin
                    // channel space holds four groups of eight
                    upd_valid <= 1'b1;
                    upd_req   <= '{kind: UPD_CH, grp: {1'b0, sel_reg[4:3]},
                                   idx: {2'b00, sel_reg[2:0]}, data: din};
                end else begin
                    // operator space with groups 2 to 7 of 32 slots
                    upd_valid <= 1'b1;
                    upd_req   <= '{kind: UPD_OP, grp: sel_reg[7:5],
                                   idx: sel_reg[4:0], data: din};
                end
            end else if (cen && !write) begin
                lfo_rst <= 1'b0;
            end
            // acks come last so they win over a set in the same cycle
            if (clr_ack_a)  clr_flag_a <= 1'b0;
            if (clr_ack_b)  clr_flag_b <= 1'b0;
            if (load_ack_a) load_a     <= 1'b0;
            if (load_ack_b) load_b     <= 1'b0;
        end
    end

    // busy window counted in cen pulses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            busy_cnt   <= '0;
            last_write <= 1'b0;
        end else begin
            last_write <= write;
            if (data_wr && !last_write) begin
                busy     <= 1'b1;
                busy_cnt <= '0;     // restart on a new write
            end else if (cen && busy) begin
                if (busy_cnt == 5'(`FM_BUSY_CEN - 1)) begin
                    busy <= 1'b0;
                end
                busy_cnt <= busy_cnt + 5'd1;
            end
        end
    end

endmodule

// ==== source/fm_reg_top.sv ====
// fm register subsystem top joining host decoder, update engine, slot counter and stores
`include "fm_defines.svh"

module fm_reg_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [7:0]          din,
    input  logic                write,
    input  logic                a0,
    input  logic                load_ack_a,
    input  logic                load_ack_b,
    input  logic                clr_ack_a,
    input  logic                clr_ack_b,
    output logic                busy,
    output fm_pkg::fm_globals_t globals,
    output logic                lfo_rst,
    output logic                load_a,
    output logic                load_b,
    output logic                clr_flag_a,
    output logic                clr_flag_b,
    output logic [4:0]          cur_slot,
    output logic                zero,
    output fm_pkg::ch_params_t  ch_params,
    output fm_pkg::op_params_t  op_params
);
    import fm_pkg::*;

    logic       upd_valid;
    upd_req_t   upd_req;
    logic [2:0] ch_rd_idx;
    logic [4:0] op_rd_idx;
    logic       ch_we;
    logic       op_we;
    ch_params_t ch_wr_data;
    ch_params_t ch_rd_data;
    op_params_t op_wr_data;
    op_params_t op_rd_data;

    fm_mmr u_mmr (
        .clk, .rst, .cen, .din, .write, .a0,
        .load_ack_a, .load_ack_b, .clr_ack_a, .clr_ack_b,
        .busy, .globals, .lfo_rst, .load_a, .load_b, .clr_flag_a, .clr_flag_b,
        .upd_valid, .upd_req
    );

    fm_update_fsm u_update_fsm (
        .clk, .rst, .upd_valid, .upd_req, .ch_rd_data, .op_rd_data,
        .ch_rd_idx, .op_rd_idx, .ch_we, .op_we, .ch_wr_data, .op_wr_data
    );

    fm_slot_counter u_slot_counter (.clk, .rst, .cen, .cur_slot, .zero);

    // write and update read share the index driven by the update engine
    fm_slot_regs #(.payload_t(ch_params_t), .DEPTH(`FM_CHANNELS)) u_ch_regs (
        .clk, .rst, .we(ch_we), .wr_idx(ch_rd_idx), .wr_data(ch_wr_data),
        .upd_idx(ch_rd_idx), .slot_idx(cur_slot[2:0]),
        .upd_data(ch_rd_data), .slot_data(ch_params)
    );

    fm_slot_regs #(.payload_t(op_params_t), .DEPTH(`FM_SLOTS)) u_op_regs (
        .clk, .rst, .we(op_we), .wr_idx(op_rd_idx), .wr_data(op_wr_data),
        .upd_idx(op_rd_idx), .slot_idx(cur_slot),
        .upd_data(op_rd_data), .slot_data(op_params)
    );

endmodule

// ==== tb/fm_tb.sv ====
// fm register interface testbench checking random host writes against a reference model
`include "fm_defines.svh"

module fm_tb;
    import fm_pkg::*;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  din;
    logic        write;
    logic        a0;
    logic        load_ack_a;
    logic        load_ack_b;
    logic        clr_ack_a;
    logic        clr_ack_b;
    logic        busy;
    fm_globals_t globals;
    logic        lfo_rst;
    logic        load_a;
    logic        load_b;
    logic        clr_flag_a;
    logic        clr_flag_b;
    logic [4:0]  cur_slot;
    logic        zero;
    ch_params_t  ch_params;
    op_params_t  op_params;

    fm_globals_t m_glob;                // reference model
    logic [3:0]  m_flags;               // clr_b, clr_a, load_b, load_a
    ch_params_t  m_ch [`FM_CHANNELS];
    op_params_t  m_op [`FM_SLOTS];
    logic [15:0] lfsr;
    logic [7:0]  glob_addr [8];

    fm_reg_top u_dut (
        .clk, .rst, .cen, .din, .write, .a0,
        .load_ack_a, .load_ack_b, .clr_ack_a, .clr_ack_b,
        .busy, .globals, .lfo_rst, .load_a, .load_b, .clr_flag_a, .clr_flag_b,
        .cur_slot, .zero, .ch_params, .op_params
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};      // one step per bit
        end
        return v;
    endfunction

    task automatic check(input logic [63:0] act, input logic [63:0] exp, input string msg);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, msg, act, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within 200 clock cycles", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // one clk with inputs changed just after the edge and cen high on every second clk
    task automatic step();
        @(posedge clk);
        #2;
        cen = rst ? 1'b0 : ~cen;
    endtask

    task automatic wait_busy_low();
        int n;
        n = 0;
        while (busy) begin
            step();
            n++;
            if (n > 200) report_timeout("busy falling");
        end
    endtask

    task automatic model_write(input logic [7:0] addr, input logic [7:0] d);
        int idx;
        idx = addr[4:0];
        if (addr >= `FM_OP_BASE) begin
            case (addr[7:5])
                3'd2: {m_op[idx].dt1, m_op[idx].mul} = {d[6:4], d[3:0]};
                3'd3: m_op[idx].tl = d[6:0];
                3'd4: {m_op[idx].ks, m_op[idx].ar} = {d[7:6], d[4:0]};
                3'd5: {m_op[idx].amsen, m_op[idx].d1r} = {d[7], d[4:0]};
                3'd6: {m_op[idx].dt2, m_op[idx].d2r} = {d[7:6], d[4:0]};
                default: {m_op[idx].d1l, m_op[idx].rr} = {d[7:4], d[3:0]};
            endcase
        end else if (addr >= `FM_CH_BASE) begin
            idx = addr[2:0];
            case (addr[4:3])
                2'd0: {m_ch[idx].rl, m_ch[idx].fb, m_ch[idx].con} = d;
                2'd1: m_ch[idx].kc = d[6:0];
                2'd2: m_ch[idx].kf = d[7:2];
                default: {m_ch[idx].pms, m_ch[idx].ams} = {d[6:4], d[1:0]};
            endcase
        end else begin
            case (addr)
                `FM_REG_KON: begin
                    for (int n = 0; n < `FM_KON_OPS; n++) begin
                        m_op[n * 8 + d[2:0]].keyon = d[3 + n];
                    end
                end
                `FM_REG_NOISE: {m_glob.ne, m_glob.nfrq} = {d[7], d[4:0]};
                `FM_REG_CLKA1: m_glob.value_a[9:2] = d;
                `FM_REG_CLKA2: m_glob.value_a[1:0] = d[1:0];
                `FM_REG_CLKB:  m_glob.value_b = d;
                `FM_REG_TIMER: begin
                    {m_glob.enable_irq_b, m_glob.enable_irq_a} = d[3:2];
                    m_flags = m_flags | {d[5], d[4], d[1], d[0]};
                end
                `FM_REG_LFRQ:  m_glob.lfo_freq = d;
                `FM_REG_PMDAMD: begin
                    if (d[7]) m_glob.lfo_pmd = d[6:0];
                    else m_glob.lfo_amd = d[6:0];
                end
                `FM_REG_CTW: {m_glob.ct2, m_glob.ct1, m_glob.lfo_w} = {d[7:6], d[1:0]};
                default: ;
            endcase
        end
    endtask

    // address cycle then idle gap then data cycle and return just after the data edge
    task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
        wait_busy_low();
        write = 1'b1;
        a0 = 1'b0;
        din = addr;
        step();
        write = 1'b0;
        step();
        write = 1'b1;
        a0 = 1'b1;
        din = data;
        step();
        write = 1'b0;
        a0 = 1'b0;
        model_write(addr, data);
    endtask

    task automatic check_globals();
        check(globals, m_glob, "globals");
        check({clr_flag_b, clr_flag_a, load_b, load_a}, m_flags, "timer flags");
    endtask

    // one full slot revolution from slot 0
    task automatic check_revolution();
        int n;
        logic [4:0] exp_slot;
        logic cen_now;
        n = 0;
        while (!zero) begin
            step();
            n++;
            if (n > 200) report_timeout("slot zero");
        end
        exp_slot = '0;
        for (int i = 0; i < 2 * `FM_SLOTS; i++) begin
            check(cur_slot, exp_slot, "cur_slot");
            check(zero, exp_slot == 5'd0, "zero");
            check(op_params, m_op[exp_slot], "op_params");
            check(ch_params, m_ch[exp_slot[2:0]], "ch_params");
            cen_now = cen;
            step();
            if (cen_now) exp_slot++;
        end
    endtask

    initial begin
        logic [7:0] addr;
        logic       cen_now;
        int         n;
        int         count;
        lfsr = 16'd30848;
        glob_addr = '{`FM_REG_NOISE, `FM_REG_CLKA1, `FM_REG_CLKA2, `FM_REG_CLKB,
                      `FM_REG_TIMER, `FM_REG_LFRQ, `FM_REG_PMDAMD, `FM_REG_CTW};
        rst = 1'b1;
        cen = 1'b0;
        din = '0;
        write = 1'b0;
        a0 = 1'b0;
        load_ack_a = 1'b0;
        load_ack_b = 1'b0;
        clr_ack_a = 1'b0;
        clr_ack_b = 1'b0;
        m_glob = '0;
        m_flags = '0;
        for (int i = 0; i < `FM_CHANNELS; i++) m_ch[i] = '0;
        for (int i = 0; i < `FM_SLOTS; i++) m_op[i] = '0;
        repeat (3) step();
        rst = 1'b0;

        check(busy, 1'b0, "busy after reset");
        check(lfo_rst, 1'b0, "lfo_rst after reset");
        check_globals();
        check_revolution();

        for (int i = 0; i < 24; i++) begin      // global registers
            addr = glob_addr[rand_bits(3)];
            host_write(addr, rand_bits(8));
            step();
            step();
            check_globals();
        end

        for (int i = 0; i < 24; i++) begin      // channel and operator entries
            if (rand_bits(1) != 0) begin
                addr = `FM_CH_BASE | rand_bits(5);
            end else begin
                addr = rand_bits(8);
                if (addr < `FM_OP_BASE) addr = addr | `FM_OP_BASE;
            end
            host_write(addr, rand_bits(8));
            wait_busy_low();
            check_revolution();
        end

        for (int i = 0; i < 10; i++) begin
            host_write(`FM_REG_KON, rand_bits(8));
            wait_busy_low();
            check_revolution();
            check_globals();
        end

        // address write alone leaves busy low
        wait_busy_low();
        write = 1'b1;
        din = `FM_REG_LFRQ;
        step();
        write = 1'b0;
        repeat (40) begin
            check(busy, 1'b0, "busy after address write");
            step();
        end

        host_write(`FM_REG_LFRQ, rand_bits(8));
        check(busy, 1'b1, "busy after data write");
        count = 0;
        n = 0;
        while (busy) begin
            cen_now = cen;
            step();
            if (cen_now) count++;
            n++;
            if (n > 200) report_timeout("busy falling");
        end
        check(count, `FM_BUSY_CEN, "cen pulses while busy");
        check_globals();

        host_write(`FM_REG_TIMER, 8'h33 | (rand_bits(2) << 2));
        repeat (6) begin
            step();
            check_globals();    // flags hold until acked
        end
        clr_ack_a = 1'b1;
        load_ack_b = 1'b1;
        step();
        clr_ack_a = 1'b0;
        load_ack_b = 1'b0;
        m_flags = m_flags & 4'b1001;
        check_globals();
        clr_ack_b = 1'b1;
        load_ack_a = 1'b1;
        step();
        clr_ack_b = 1'b0;
        load_ack_a = 1'b0;
        m_flags = '0;
        check_globals();

        host_write(`FM_REG_LFO_RST, rand_bits(8));
        check(lfo_rst, 1'b1, "lfo_rst after write");
        n = 0;
        cen_now = 1'b0;
        while (!cen_now) begin
            cen_now = cen;
            step();
            n++;
            if (n > 200) report_timeout("cen pulse");
        end
        check(lfo_rst, 1'b0, "lfo_rst after cen");

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
source/fm_pkg.sv
source/fm_slot_regs.sv
source/fm_slot_counter.sv
source/fm_update_fsm.sv
source/fm_mmr.sv
source/fm_reg_top.sv
tb/fm_tb.sv
